// ==== logic/core_pkg.sv ====
// Shared definitions of the pipeline core
// Widths, reset vector, opcodes, forwarding selects
// ALU and writeback codes, instruction word union

package core_pkg;

	localparam int xlen     = 32; // Data word
	localparam int reg_bits = 5;  // Register index
	localparam int pc_bits  = 32;

	localparam logic [pc_bits-1:0] reset_pc = '0; // First fetch
	localparam logic [xlen-1:0]    nop_inst = 32'h0000_0013; // addi x0, x0, 0

	////////////////////////////// Opcodes
	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_lui    = 7'b0110111;

	// Operand source picked in decode
	localparam logic [1:0] fwd_none = 2'd0; // Register file
	localparam logic [1:0] fwd_exe  = 2'd1;
	localparam logic [1:0] fwd_mem  = 2'd2;
	localparam logic [1:0] fwd_wb   = 2'd3;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	typedef enum logic [1:0] {
		wb_pc4, // Link address
		wb_alu,
		wb_imm, // LUI
		wb_load
	} wb_sel_e;

	////////////////////////////// Instruction word
	typedef union packed {
		struct packed {
			logic [6:0]          funct7;
			logic [reg_bits-1:0] rs2;
			logic [reg_bits-1:0] rs1;
			logic [2:0]          funct3;
			logic [reg_bits-1:0] rd;
			logic [6:0]          opcode;
		} r;
		struct packed {
			logic [11:0]         imm12;
			logic [reg_bits-1:0] rs1;
			logic [2:0]          funct3;
			logic [reg_bits-1:0] rd;
			logic [6:0]          opcode;
		} i;
		struct packed {
			logic [6:0]          imm_hi;
			logic [reg_bits-1:0] rs2;
			logic [reg_bits-1:0] rs1;
			logic [2:0]          funct3;
			logic [4:0]          imm_lo;
			logic [6:0]          opcode;
		} s;
	} inst_u;

endpackage

// ==== logic/core_ifs.sv ====
// Forwarding bus from execute, memory and writeback back to decode
// Hazard control bus between decode, execute, fetch and the controller

interface fwd_if
	import core_pkg::*;
();
	logic [reg_bits-1:0] exe_rd;
	logic                exe_wr_en;
	logic                exe_is_load;  // Result not ready in execute
	logic [xlen-1:0]     exe_result;
	logic [reg_bits-1:0] mem_rd;
	logic                mem_wr_en;
	logic [xlen-1:0]     mem_result;   // Includes load data
	logic [reg_bits-1:0] wb_rd;
	logic                wb_wr_en;
	logic [xlen-1:0]     wb_result;    // Also the regfile write data

	modport exe_src (output exe_rd, exe_wr_en, exe_is_load, exe_result);
	modport mem_src (output mem_rd, mem_wr_en, mem_result, wb_rd, wb_wr_en, wb_result);
	modport sink (input exe_rd, exe_wr_en, exe_is_load, exe_result, mem_rd, mem_wr_en,
		mem_result, wb_rd, wb_wr_en, wb_result);
endinterface

interface hazard_if
	import core_pkg::*;
(
	input logic clk
);
	logic [1:0]          fwd_a, fwd_b;         // One of fwd_none .. fwd_wb
	logic                stall_id;             // Load-use hold
	logic                flush_id, flush_exe;
	logic [reg_bits-1:0] id_rs1, id_rs2;
	logic                id_use_rs1, id_use_rs2;
	logic                jal_redirect;         // JAL sitting in decode
	logic                branch_taken;         // Resolved in execute

	modport ctrl (input clk, id_rs1, id_rs2, id_use_rs1, id_use_rs2, jal_redirect, branch_taken,
		output fwd_a, fwd_b, stall_id, flush_id, flush_exe);
	modport dec (input fwd_a, fwd_b, stall_id, flush_exe,
		output id_rs1, id_rs2, id_use_rs1, id_use_rs2, jal_redirect);
	modport exe (output branch_taken);
	modport fetch (input stall_id, flush_id, branch_taken, jal_redirect);
endinterface

// ==== logic/regfile.sv ====
// Register file, 32 x 32 bit
// Two async read ports, one write port, x0 tied to zero

module regfile
	import core_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic [reg_bits-1:0] rs1,
	input  logic [reg_bits-1:0] rs2,
	output logic [xlen-1:0]     rd1,
	output logic [xlen-1:0]     rd2,
	input  logic                wr_en,
	input  logic [reg_bits-1:0] wr_addr,
	input  logic [xlen-1:0]     wr_data
);

	logic [xlen-1:0] regs [1:31]; // No storage for x0

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/fetch_stage.sv ====
// Fetch stage
// Program counter, next-PC selection, IF/ID register

module fetch_stage
	import core_pkg::*;
(
	input  logic               clk,
	input  logic               arst_n,
	hazard_if.fetch            hz,
	input  logic [pc_bits-1:0] br_target,
	input  logic [pc_bits-1:0] jal_target,
	output logic [pc_bits-1:0] imem_addr,
	input  logic [xlen-1:0]    imem_data,
	output inst_u              id_inst,
	output logic [pc_bits-1:0] id_pc
);

	logic [pc_bits-1:0] pc;
	logic [pc_bits-1:0] pc_next;

	// Branch beats JAL, an older instruction wins
	always_comb begin
		if (hz.branch_taken)
			pc_next = br_target;
		else if (hz.jal_redirect)
			pc_next = jal_target;
		else if (hz.stall_id)
			pc_next = pc; // Refetch same word
		else
			pc_next = pc + pc_bits'(4);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= reset_pc;
		else
			pc <= pc_next;
	end

	assign imem_addr = pc; // Async instruction memory

	////////////////////////////// IF/ID
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_inst <= nop_inst;
			id_pc   <= reset_pc;
		end else if (hz.flush_id) begin
			id_inst <= nop_inst; // Bubble
		end else if (!hz.stall_id) begin
			id_inst <= imem_data;
			id_pc   <= pc;
		end
	end

endmodule

// ==== logic/decode_stage.sv ====
// Decode stage
// Field decode, immediates, operand forwarding, JAL target
// ID/EXE register

module decode_stage
	import core_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	input  inst_u               id_inst,
	input  logic [pc_bits-1:0]  id_pc,
	fwd_if.sink                 fwd,
	hazard_if.dec               hz,
	output logic [pc_bits-1:0]  jal_target,
	output logic [xlen-1:0]     ex_op_a,
	output logic [xlen-1:0]     ex_op_b,
	output logic [xlen-1:0]     ex_store_data,
	output logic [xlen-1:0]     ex_imm,
	output logic [pc_bits-1:0]  ex_pc,
	output logic [reg_bits-1:0] ex_rd,
	output alu_op_e             ex_alu_op,
	output wb_sel_e             ex_wb_sel,
	output logic                ex_wr_en,
	output logic                ex_is_load,
	output logic                ex_is_store,
	output logic                ex_is_branch,
	output logic                ex_branch_ne
);

	logic [6:0]      opcode;
	logic            is_rtype, is_itype, is_load, is_store, is_branch, is_jal, is_lui;
	logic            wr_en, use_imm, bubble;
	logic [xlen-1:0] imm, rd1, rd2, src1, src2;
	alu_op_e         alu_op;
	wb_sel_e         wb_sel;

	assign opcode    = id_inst.r.opcode;
	assign is_rtype  = opcode == op_rtype;
	assign is_itype  = opcode == op_itype;
	assign is_load   = opcode == op_load;
	assign is_store  = opcode == op_store;
	assign is_branch = opcode == op_branch;
	assign is_jal    = opcode == op_jal;
	assign is_lui    = opcode == op_lui;
	assign wr_en     = is_rtype | is_itype | is_load | is_jal | is_lui;
	assign use_imm   = is_itype | is_load | is_store; // Operand B from immediate

	regfile rf_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs1     (id_inst.r.rs1),
		.rs2     (id_inst.r.rs2),
		.rd1     (rd1),
		.rd2     (rd2),
		.wr_en   (fwd.wb_wr_en), // Writeback port
		.wr_addr (fwd.wb_rd),
		.wr_data (fwd.wb_result)
	);

	////////////////////////////// Immediates
	always_comb begin
		case (opcode)
			op_store:  imm = {{20{id_inst.s.imm_hi[6]}}, id_inst.s.imm_hi, id_inst.s.imm_lo};
			op_branch: imm = {{19{id_inst.s.imm_hi[6]}}, id_inst.s.imm_hi[6], id_inst.s.imm_lo[0],
				id_inst.s.imm_hi[5:0], id_inst.s.imm_lo[4:1], 1'b0};
			op_jal:    imm = {{11{id_inst.i.imm12[11]}}, id_inst.i.imm12[11], id_inst.i.rs1,
				id_inst.i.funct3, id_inst.i.imm12[0], id_inst.i.imm12[10:1], 1'b0};
			op_lui:    imm = {id_inst.i.imm12, id_inst.i.rs1, id_inst.i.funct3, 12'b0};
			default:   imm = {{20{id_inst.i.imm12[11]}}, id_inst.i.imm12}; // I-type and loads
		endcase
	end

	// ALU op, add for address and don't-care paths
	always_comb begin
		alu_op = alu_add;
		if (is_rtype || is_itype) begin
			case (id_inst.r.funct3)
				3'b000:  alu_op = (is_rtype && id_inst.r.funct7[5]) ? alu_sub : alu_add;
				3'b001:  alu_op = alu_sll;
				3'b010:  alu_op = alu_slt;
				3'b011:  alu_op = alu_sltu;
				3'b100:  alu_op = alu_xor;
				3'b101:  alu_op = id_inst.r.funct7[5] ? alu_sra : alu_srl;
				3'b110:  alu_op = alu_or;
				default: alu_op = alu_and;
			endcase
		end
	end

	always_comb begin
		if (is_jal)
			wb_sel = wb_pc4;
		else if (is_lui)
			wb_sel = wb_imm;
		else if (is_load)
			wb_sel = wb_load;
		else
			wb_sel = wb_alu;
	end

	////////////////////////////// Forwarding
	function automatic logic [xlen-1:0] fwd_value(input logic [1:0] sel,
		input logic [xlen-1:0] rf);
		case (sel)
			fwd_exe: return fwd.exe_result;
			fwd_mem: return fwd.mem_result;
			fwd_wb:  return fwd.wb_result; // Same-cycle regfile write
			default: return rf;
		endcase
	endfunction

	assign src1 = fwd_value(hz.fwd_a, rd1);
	assign src2 = fwd_value(hz.fwd_b, rd2);

	assign hz.id_rs1       = id_inst.r.rs1;
	assign hz.id_rs2       = id_inst.r.rs2;
	assign hz.id_use_rs1   = is_rtype | is_itype | is_load | is_store | is_branch;
	assign hz.id_use_rs2   = is_rtype | is_store | is_branch;
	assign hz.jal_redirect = is_jal;
	assign jal_target      = id_pc + imm;

	////////////////////////////// ID/EXE
	assign bubble = hz.stall_id | hz.flush_exe;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_wr_en     <= 1'b0;
			ex_is_load   <= 1'b0;
			ex_is_store  <= 1'b0;
			ex_is_branch <= 1'b0;
		end else begin
			ex_wr_en     <= wr_en & ~bubble;
			ex_is_load   <= is_load & ~bubble;
			ex_is_store  <= is_store & ~bubble;
			ex_is_branch <= is_branch & ~bubble;
		end
	end

	always_ff @(posedge clk) begin
		ex_op_a       <= src1;
		ex_op_b       <= use_imm ? imm : src2;
		ex_store_data <= src2;
		ex_imm        <= imm;
		ex_pc         <= id_pc;
		ex_rd         <= id_inst.r.rd;
		ex_alu_op     <= alu_op;
		ex_wb_sel     <= wb_sel;
		ex_branch_ne  <= id_inst.r.funct3[0]; // BNE
	end

endmodule

// ==== logic/execute_stage.sv ====
// Execute stage
// ALU, BEQ/BNE evaluation, branch target, EXE/MEM register

module execute_stage
	import core_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic [xlen-1:0]     ex_op_a,
	input  logic [xlen-1:0]     ex_op_b,
	input  logic [xlen-1:0]     ex_store_data,
	input  logic [xlen-1:0]     ex_imm,
	input  logic [pc_bits-1:0]  ex_pc,
	input  logic [reg_bits-1:0] ex_rd,
	input  alu_op_e             ex_alu_op,
	input  wb_sel_e             ex_wb_sel,
	input  logic                ex_wr_en,
	input  logic                ex_is_load,
	input  logic                ex_is_store,
	input  logic                ex_is_branch,
	input  logic                ex_branch_ne,
	fwd_if.exe_src              fwd,
	hazard_if.exe               hz,
	output logic [pc_bits-1:0]  br_target,
	output logic [xlen-1:0]     mem_addr,  // Data memory port, unregistered
	output logic [xlen-1:0]     mem_wdata,
	output logic                mem_write,
	output logic                mem_read,
	output logic [reg_bits-1:0] mem_rd,
	output logic                mem_wr_en,
	output wb_sel_e             mem_wb_sel,
	output logic [xlen-1:0]     mem_alu,
	output logic [xlen-1:0]     mem_imm,
	output logic [pc_bits-1:0]  mem_pc4
);

	logic [xlen-1:0]    alu_y;
	logic [4:0]         shamt;
	logic [pc_bits-1:0] pc4;

	assign shamt = ex_op_b[4:0];
	assign pc4   = ex_pc + pc_bits'(4);

	always_comb begin
		case (ex_alu_op)
			alu_sub:  alu_y = ex_op_a - ex_op_b;
			alu_and:  alu_y = ex_op_a & ex_op_b;
			alu_or:   alu_y = ex_op_a | ex_op_b;
			alu_xor:  alu_y = ex_op_a ^ ex_op_b;
			alu_slt:  alu_y = xlen'($signed(ex_op_a) < $signed(ex_op_b));
			alu_sltu: alu_y = xlen'(ex_op_a < ex_op_b);
			alu_sll:  alu_y = ex_op_a << shamt;
			alu_srl:  alu_y = ex_op_a >> shamt;
			alu_sra:  alu_y = $signed(ex_op_a) >>> shamt;
			default:  alu_y = ex_op_a + ex_op_b;
		endcase
	end

	// Taken when equality disagrees with BNE
	assign hz.branch_taken = ex_is_branch && ((ex_op_a == ex_op_b) != ex_branch_ne);
	assign br_target       = ex_pc + ex_imm;

	////////////////////////////// Forwarding source
	assign fwd.exe_rd      = ex_rd;
	assign fwd.exe_wr_en   = ex_wr_en;
	assign fwd.exe_is_load = ex_is_load; // Data comes a stage later

	always_comb begin
		case (ex_wb_sel)
			wb_pc4:  fwd.exe_result = pc4;
			wb_imm:  fwd.exe_result = ex_imm;
			default: fwd.exe_result = alu_y;
		endcase
	end

	assign mem_addr  = alu_y;
	assign mem_wdata = ex_store_data;
	assign mem_write = ex_is_store;
	assign mem_read  = ex_is_load;

	////////////////////////////// EXE/MEM
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mem_wr_en <= 1'b0;
		else
			mem_wr_en <= ex_wr_en;
	end

	always_ff @(posedge clk) begin
		mem_rd     <= ex_rd;
		mem_wb_sel <= ex_wb_sel;
		mem_alu    <= alu_y;
		mem_imm    <= ex_imm;
		mem_pc4    <= pc4;
	end

	// The flush behind a taken branch leaves a bubble in execute
	a_branch_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		hz.branch_taken |=> !hz.branch_taken);

endmodule

// ==== logic/memory_stage.sv ====
// Memory stage
// Dual-port data memory, core and controller side
// MEM/WB register, writeback selection

module memory_stage
	import core_pkg::*;
#(
	parameter  int dmem_words = 64,
	localparam int aw         = $clog2(dmem_words)
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic [xlen-1:0]     mem_addr,
	input  logic [xlen-1:0]     mem_wdata,
	input  logic                mem_write,
	input  logic                mem_read,
	input  logic [reg_bits-1:0] mem_rd,
	input  logic                mem_wr_en,
	input  wb_sel_e             mem_wb_sel,
	input  logic [xlen-1:0]     mem_alu,
	input  logic [xlen-1:0]     mem_imm,
	input  logic [pc_bits-1:0]  mem_pc4,
	fwd_if.mem_src              fwd,
	output logic                wb_wr_en,
	output logic [reg_bits-1:0] wb_rd,
	output logic [xlen-1:0]     wb_data,
	input  logic                con_write,
	input  logic [aw-1:0]       con_addr,
	input  logic [xlen-1:0]     con_in,
	output logic [xlen-1:0]     con_out
);

	logic [xlen-1:0] dmem [dmem_words];
	logic [xlen-1:0] rdata;      // Core read, one stage after address
	logic [aw-1:0]   core_idx;
	logic [xlen-1:0] mem_result;

	assign core_idx = mem_addr[aw+1:2]; // Word index

	// Memory starts cleared, core store lands after a controller write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < dmem_words; i++)
				dmem[i] <= '0;
		end else begin
			if (con_write)
				dmem[con_addr] <= con_in;
			if (mem_write)
				dmem[core_idx] <= mem_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_read)
			rdata <= dmem[core_idx];
		con_out <= dmem[con_addr]; // Controller read port
	end

	always_comb begin
		case (mem_wb_sel)
			wb_pc4:  mem_result = mem_pc4;
			wb_imm:  mem_result = mem_imm;
			wb_load: mem_result = rdata;
			default: mem_result = mem_alu;
		endcase
	end

	////////////////////////////// MEM/WB
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_wr_en <= 1'b0;
		else
			wb_wr_en <= mem_wr_en;
	end

	always_ff @(posedge clk) begin
		wb_rd   <= mem_rd;
		wb_data <= mem_result;
	end

	assign fwd.mem_rd     = mem_rd;
	assign fwd.mem_wr_en  = mem_wr_en;
	assign fwd.mem_result = mem_result;
	assign fwd.wb_rd      = wb_rd;
	assign fwd.wb_wr_en   = wb_wr_en;
	assign fwd.wb_result  = wb_data;

	// Address from the execute ALU stays word aligned and in range
	a_addr_range: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_read || mem_write) |-> (mem_addr[1:0] == 2'b00 && (mem_addr >> 2) < dmem_words));

endmodule

// ==== logic/hazard_ctrl.sv ====
// Hazard controller
// Forwarding source selection, load-use stall, redirect flushes

module hazard_ctrl
	import core_pkg::*;
(
	fwd_if.sink    fwd,
	hazard_if.ctrl hz
);

	logic load_use;

	// Youngest producer first
	function automatic logic [1:0] pick_src(input logic [reg_bits-1:0] rs);
		if (rs == '0)
			return fwd_none; // x0 never forwarded
		if (fwd.exe_wr_en && fwd.exe_rd == rs)
			return fwd_exe;
		if (fwd.mem_wr_en && fwd.mem_rd == rs)
			return fwd_mem;
		if (fwd.wb_wr_en && fwd.wb_rd == rs)
			return fwd_wb;
		return fwd_none;
	endfunction

	assign hz.fwd_a = pick_src(hz.id_rs1);
	assign hz.fwd_b = pick_src(hz.id_rs2);

	// Load result only exists after memory
	assign load_use = fwd.exe_is_load && fwd.exe_wr_en && fwd.exe_rd != '0 &&
		((hz.id_use_rs1 && hz.id_rs1 == fwd.exe_rd) ||
		 (hz.id_use_rs2 && hz.id_rs2 == fwd.exe_rd));

	assign hz.stall_id  = load_use;
	assign hz.flush_id  = hz.branch_taken | hz.jal_redirect; // Drop wrong-path fetch
	assign hz.flush_exe = hz.branch_taken;

	// A load in execute excludes a branch there, and the inserted bubble ends the stall
	a_stall_once: assert property (@(posedge hz.clk)
		hz.stall_id |-> !hz.branch_taken ##1 !hz.stall_id);

endmodule

// ==== logic/core.sv ====
// Five-stage RV32I core top level
// Stages, hazard controller, forwarding and hazard buses
// Instruction memory and controller ports

module core
	import core_pkg::*;
#(
	parameter int dmem_words = 64
) (
	input  logic                          clk,
	input  logic                          arst_n,
	output logic [pc_bits-1:0]            imem_addr,
	input  logic [xlen-1:0]               imem_data,
	input  logic                          con_write,
	input  logic [$clog2(dmem_words)-1:0] con_addr,
	input  logic [xlen-1:0]               con_in,
	output logic [xlen-1:0]               con_out
);

	logic [pc_bits-1:0]  br_target, jal_target;
	inst_u               id_inst;
	logic [pc_bits-1:0]  id_pc;

	// ID/EXE
	logic [xlen-1:0]     ex_op_a, ex_op_b, ex_store_data, ex_imm;
	logic [pc_bits-1:0]  ex_pc;
	logic [reg_bits-1:0] ex_rd;
	alu_op_e             ex_alu_op;
	wb_sel_e             ex_wb_sel;
	logic                ex_wr_en, ex_is_load, ex_is_store, ex_is_branch, ex_branch_ne;

	// EXE/MEM
	logic [xlen-1:0]     mem_addr, mem_wdata, mem_alu, mem_imm;
	logic                mem_write, mem_read, mem_wr_en;
	logic [reg_bits-1:0] mem_rd;
	wb_sel_e             mem_wb_sel;
	logic [pc_bits-1:0]  mem_pc4;

	fwd_if    fwd_bus ();
	hazard_if hz_bus (.clk(clk));

	fetch_stage fetch_i (
		.clk(clk), .arst_n(arst_n), .hz(hz_bus.fetch),
		.br_target(br_target), .jal_target(jal_target),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.id_inst(id_inst), .id_pc(id_pc)
	);

	decode_stage decode_i (
		.clk(clk), .arst_n(arst_n), .id_inst(id_inst), .id_pc(id_pc),
		.fwd(fwd_bus.sink), .hz(hz_bus.dec), .jal_target(jal_target),
		.ex_op_a(ex_op_a), .ex_op_b(ex_op_b), .ex_store_data(ex_store_data),
		.ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rd(ex_rd), .ex_alu_op(ex_alu_op),
		.ex_wb_sel(ex_wb_sel), .ex_wr_en(ex_wr_en), .ex_is_load(ex_is_load),
		.ex_is_store(ex_is_store), .ex_is_branch(ex_is_branch), .ex_branch_ne(ex_branch_ne)
	);

	execute_stage execute_i (
		.clk(clk), .arst_n(arst_n),
		.ex_op_a(ex_op_a), .ex_op_b(ex_op_b), .ex_store_data(ex_store_data),
		.ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rd(ex_rd), .ex_alu_op(ex_alu_op),
		.ex_wb_sel(ex_wb_sel), .ex_wr_en(ex_wr_en), .ex_is_load(ex_is_load),
		.ex_is_store(ex_is_store), .ex_is_branch(ex_is_branch), .ex_branch_ne(ex_branch_ne),
		.fwd(fwd_bus.exe_src), .hz(hz_bus.exe), .br_target(br_target),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_write(mem_write),
		.mem_read(mem_read), .mem_rd(mem_rd), .mem_wr_en(mem_wr_en),
		.mem_wb_sel(mem_wb_sel), .mem_alu(mem_alu), .mem_imm(mem_imm), .mem_pc4(mem_pc4)
	);

	// Writeback reaches the register file through the forwarding bus
	memory_stage #(.dmem_words(dmem_words)) memory_i (
		.clk(clk), .arst_n(arst_n),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_write(mem_write),
		.mem_read(mem_read), .mem_rd(mem_rd), .mem_wr_en(mem_wr_en),
		.mem_wb_sel(mem_wb_sel), .mem_alu(mem_alu), .mem_imm(mem_imm), .mem_pc4(mem_pc4),
		.fwd(fwd_bus.mem_src), .wb_wr_en(), .wb_rd(), .wb_data(),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	hazard_ctrl hazard_i (
		.fwd(fwd_bus.sink),
		.hz(hz_bus.ctrl)
	);

endmodule

// ==== sim/core_checker.sv ====
// Readback checker for the pipeline core
// Reference ISA model over the program, expected data memory
// Reset vector, controller port comparison and error counting

module core_checker
	import core_pkg::*;
#(
	parameter  int dmem_words = 64,
	parameter  int prog_len   = 69,
	localparam int aw         = $clog2(dmem_words)
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [pc_bits-1:0] imem_addr,
	input  logic               check_en,
	input  logic               con_write,
	input  logic [aw-1:0]      con_addr,
	input  logic [xlen-1:0]    con_in,
	input  logic [xlen-1:0]    con_out,
	output int                 checks,
	output int                 errors
);

	localparam int step_limit = 2 * prog_len; // Forward-only program
	localparam logic [31:0] self_loop = 32'h0000_006f;

	logic [xlen-1:0] prog    [prog_len]; // Loaded by the testbench
	logic [xlen-1:0] exp_mem [dmem_words];
	logic            en_q;
	logic [aw-1:0]   addr_q;

	function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b; // SUB or ADD
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				else
					return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	////////////////////////////// Reference model
	// Step count to the self-loop or -1 when it is never reached
	function automatic int run_reference();
		logic [xlen-1:0] x [32];
		logic [31:0]     pc, next, word, ea, imm_b, imm_j;
		inst_u           iw;
		for (int r = 0; r < 32; r++)
			x[r] = '0;
		for (int w = 0; w < dmem_words; w++)
			exp_mem[w] = '0; // Memory clears on reset
		pc = reset_pc;
		for (int steps = 0; steps < step_limit; steps++) begin
			word  = ((pc >> 2) < prog_len) ? prog[pc >> 2] : self_loop;
			iw    = word;
			if (word == self_loop)
				return steps;
			next  = pc + 32'd4;
			imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
			imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
			case (iw.r.opcode)
				op_rtype: x[iw.r.rd] = alu_ref(iw.r.funct3, iw.r.funct7[5],
					x[iw.r.rs1], x[iw.r.rs2]);
				op_itype: x[iw.i.rd] = alu_ref(iw.i.funct3, 1'b0, x[iw.i.rs1],
					{{20{iw.i.imm12[11]}}, iw.i.imm12});
				op_lui: x[iw.r.rd] = {word[31:12], 12'd0};
				op_load: begin
					ea = x[iw.i.rs1] + {{20{iw.i.imm12[11]}}, iw.i.imm12};
					x[iw.i.rd] = exp_mem[ea[aw+1:2]];
				end
				op_store: begin
					ea = x[iw.s.rs1] + {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
					exp_mem[ea[aw+1:2]] = x[iw.s.rs2];
				end
				op_branch: begin
					if ((x[iw.r.rs1] == x[iw.r.rs2]) != iw.r.funct3[0]) // BNE flips
						next = pc + imm_b;
				end
				op_jal: begin
					x[iw.r.rd] = pc + 32'd4; // Link
					next       = pc + imm_j;
				end
				default: return -1;
			endcase
			x[0] = '0;
			pc   = next;
		end
		return -1;
	endfunction

	initial begin
		checks = 0;
		errors = 0;
		en_q   = 1'b0;
	end

	// Program is loaded and fetch sits at the reset vector when reset ends
	always @(posedge arst_n) begin
		if (imem_addr !== reset_pc) begin
			$display("Fail %0t imem_addr: got %h, expected %h", $time, imem_addr, reset_pc);
			errors <= errors + 1;
		end
		if (run_reference() < 0) begin
			$display("Reference model did not reach the self-loop");
			errors <= errors + 1;
		end
	end

	////////////////////////////// Readback compare
	always @(posedge clk) begin
		if (con_write)
			exp_mem[con_addr] <= con_in; // Controller write lands now
		if (en_q) begin
			checks <= checks + 1;
			if (con_out !== exp_mem[addr_q]) begin
				$display("Fail %0t con_out: got %h, expected %h at word %0d",
					$time, con_out, exp_mem[addr_q], addr_q);
				errors <= errors + 1;
			end
		end
		en_q   <= check_en; // Data shows one cycle after the address
		addr_q <= con_addr;
	end

endmodule

// ==== sim/core_tb.sv ====
// Testbench top for the pipeline core
// Clock, reset, random program, instruction memory model
// Data memory readback sweep, controller writes, timeout, report

module core_tb
	import core_pkg::*;
();

	localparam int dmem_words     = 64;
	localparam int aw             = $clog2(dmem_words);
	localparam int body_len       = 60;
	localparam int prog_len       = body_len + 9; // Body, 8 stores, self-loop
	localparam int run_cycles     = 3 * prog_len + 20;
	localparam int timeout_cycles = run_cycles + 100;
	localparam int sweep_words    = 40;
	localparam int con_tests      = 4;
	localparam logic [31:0] self_loop = 32'h0000_006f; // jal x0, 0

	logic               clk;
	logic               arst_n;
	logic [pc_bits-1:0] imem_addr;
	logic [xlen-1:0]    imem_data;
	logic               con_write;
	logic               check_en;
	logic [aw-1:0]      con_addr;
	logic [xlen-1:0]    con_in;
	logic [xlen-1:0]    con_out;
	logic [xlen-1:0]    prog [prog_len];
	logic [31:0]        rng;
	int                 cycles;
	int                 checks;
	int                 errors;

	core #(.dmem_words(dmem_words)) core_i (
		.clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_data(imem_data),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	core_checker #(.dmem_words(dmem_words), .prog_len(prog_len)) checker_i (
		.clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .check_en(check_en),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out),
		.checks(checks), .errors(errors)
	);

	// Async instruction memory that reads the self-loop past the end
	assign imem_data = (imem_addr[31:2] < prog_len) ? prog[imem_addr[31:2]] : self_loop;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [4:0] pick_reg(input logic [31:0] r);
		return 5'(r % 7 + 1); // x1 .. x7
	endfunction

	////////////////////////////// Program
	task automatic build_program();
		logic [31:0] r0, r1;
		logic [4:0]  rd, rs1, rs2, last_rd;
		logic [2:0]  f3, fi;
		logic [12:0] off;
		logic [11:0] addr12;
		int          kind;
		last_rd = 5'd1;
		for (int i = 0; i < body_len; i++) begin
			r0     = xorshift(rng);
			r1     = xorshift(r0);
			rng    = r1;
			kind   = int'(r0 % 12);
			rd     = pick_reg(r0 >> 4);
			rs1    = (r1[1:0] != 2'b00) ? last_rd : pick_reg(r1 >> 2); // Forced chain
			rs2    = pick_reg(r1 >> 12);
			f3     = r0[26:24];
			fi     = (f3 == 3'd1 || f3 == 3'd3 || f3 == 3'd5) ? 3'd0 : f3; // No shift imm
			off    = r0[28] ? 13'd12 : 13'd8;
			addr12 = {6'd0, r1[7:4], 2'b00}; // Words 0 .. 15
			if (kind >= 10 && i >= body_len - 3)
				kind = 4; // Keep the final stores reachable
			case (kind)
				0, 1, 2, 3: prog[i] = {1'b0, r0[27] & (f3 == 3'd0 || f3 == 3'd5), 5'd0,
					rs2, rs1, f3, rd, op_rtype};
				4, 5, 6: prog[i] = {r1[31:20], rs1, fi, rd, op_itype};
				7:  prog[i] = {r1[31:12], rd, op_lui};
				8:  prog[i] = {addr12, 5'd0, 3'b010, rd, op_load};
				9:  prog[i] = {addr12[11:5], rs1, 5'd0, 3'b010, addr12[4:0], op_store};
				10: prog[i] = {off[12], off[10:5], rs2, rs1, 2'b00, r0[29], off[4:1], off[11],
					op_branch}; // BEQ or BNE
				default: prog[i] = {1'b0, off[10:1], off[11], 8'd0, rd, op_jal};
			endcase
			if (kind != 9 && kind != 10)
				last_rd = rd;
		end
		for (int k = 0; k < 8; k++) begin
			addr12 = 12'(128 + 4 * k); // Words 32 .. 39
			prog[body_len + k] = {addr12[11:5], 5'(k), 5'd0, 3'b010, addr12[4:0], op_store};
		end
		prog[prog_len - 1] = self_loop;
		for (int i = 0; i < prog_len; i++)
			checker_i.prog[i] = prog[i];
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Hung run guard
	initial cycles = 0;
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("Timeout, the run did not end within %0d cycles", timeout_cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		logic [aw-1:0] a;
		arst_n    = 1'b0;
		con_write = 1'b0;
		con_addr  = '0;
		con_in    = '0;
		check_en  = 1'b0;
		rng       = 32'd91;
		build_program();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		repeat (run_cycles) @(posedge clk); // Program drains into the self-loop
		for (int w = 0; w < sweep_words; w++) begin
			@(posedge clk);
			con_addr <= aw'(w);
			check_en <= 1'b1;
		end
		for (int t = 0; t < con_tests; t++) begin
			rng = xorshift(rng);
			a   = rng[aw-1:0];
			@(posedge clk);
			check_en  <= 1'b0;
			con_write <= 1'b1;
			con_addr  <= a;
			con_in    <= xorshift(rng);
			@(posedge clk);
			con_write <= 1'b0;
			check_en  <= 1'b1; // Read back the same word
		end
		@(posedge clk);
		check_en <= 1'b0;
		repeat (3) @(posedge clk);
		if (checks != sweep_words + con_tests)
			$display("Readback incomplete, %0d of %0d checks made", checks,
				sweep_words + con_tests);
		$display("Readback checks %0d, errors %0d", checks, errors);
		if (errors == 0 && checks == sweep_words + con_tests)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== sources.f ====
logic/core_pkg.sv
logic/core_ifs.sv
logic/regfile.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_ctrl.sv
logic/core.sv
sim/core_checker.sv
sim/core_tb.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - target: rtl
    files:
      - logic/core_pkg.sv
      - logic/core_ifs.sv
      - logic/regfile.sv
      - logic/fetch_stage.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/hazard_ctrl.sv
      - logic/core.sv
  - target: sim
    files:
      - sim/core_checker.sv
      - sim/core_tb.sv
